//--- buttons/button_pulser.sv
`timescale 1ns/1ns
`default_nettype none

module button_pulser (
  input  logic clk,
  input  logic rst_n_i,
  input  logic button_i,
  output logic press_o
);

  logic [1:0] sync_q; // two-flop synchroniser
  logic       last_q; // synchronised level, one cycle old
  logic       press_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sync_q  <= 2'b00;
      last_q  <= 1'b0;
      press_q <= 1'b0;
    end
    else
    begin
      sync_q  <= {sync_q[0], button_i};
      last_q  <= sync_q[1];
      press_q <= sync_q[1] & ~last_q; // rising edge only
    end
  end

  // a held button stays high in last_q, so no repeat until it drops
  assign press_o = press_q;

endmodule

`default_nettype wire

//--- common/rtc_pkg.sv
`default_nettype none

package rtc_pkg;

  localparam int DATA_W      = 8;
  localparam int ADDR_W      = 8;
  localparam int FIELD_COUNT = 8;
  localparam int FIELD_W     = 3;

  // chip register map
  localparam logic [ADDR_W-1:0] CTRL_ADDR       = 8'h02;
  localparam logic [ADDR_W-1:0] FIELD_BASE_ADDR = 8'h21; // seconds register

  // control register commands
  localparam logic [DATA_W-1:0] CTRL_RESET = 8'h10;
  localparam logic [DATA_W-1:0] CTRL_CLEAR = 8'h00;

  // reset hold between the two command writes
  localparam int                    INIT_CNT_W  = 7;
  localparam logic [INIT_CNT_W-1:0] INIT_CYCLES = 7'd74;

  // index k sits at FIELD_BASE_ADDR + k
  typedef enum logic [FIELD_W-1:0] {
    F_SECONDS,
    F_MINUTES,
    F_HOURS,
    F_DATE,
    F_MONTH,
    F_YEAR,
    F_WEEKDAY,
    F_WEEKNUM
  } field_e;

endpackage

`default_nettype wire

//--- logic/field_cursor.sv
`timescale 1ns/1ns
`default_nettype none

module field_cursor (
  input  logic           clk,
  input  logic           rst_n_i,
  input  logic           left_i,
  input  logic           right_i,
  output rtc_pkg::field_e field_o
);

  rtc_pkg::field_e field_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      field_q <= rtc_pkg::F_SECONDS;
    end
    else if (right_i && !left_i)
    begin
      if (field_q == rtc_pkg::F_WEEKNUM)
        field_q <= rtc_pkg::F_SECONDS; // wrap forward
      else
        field_q <= rtc_pkg::field_e'(field_q + 1'b1);
    end
    else if (left_i && !right_i)
    begin
      if (field_q == rtc_pkg::F_SECONDS)
        field_q <= rtc_pkg::F_WEEKNUM; // wrap back
      else
        field_q <= rtc_pkg::field_e'(field_q - 1'b1);
    end
  end

  assign field_o = field_q;

endmodule

`default_nettype wire

//--- logic/field_editor.sv
`timescale 1ns/1ns
`default_nettype none

module field_editor (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       up_i,
  input  logic                       down_i,
  input  logic                       busy_i,
  input  logic                       cmd_wr_i,
  input  logic [rtc_pkg::DATA_W-1:0] cmd_data_i,
  input  rtc_pkg::field_e            field_i,
  input  logic [rtc_pkg::DATA_W-1:0] seconds_i,
  input  logic [rtc_pkg::DATA_W-1:0] minutes_i,
  input  logic [rtc_pkg::DATA_W-1:0] hours_i,
  input  logic [rtc_pkg::DATA_W-1:0] date_i,
  input  logic [rtc_pkg::DATA_W-1:0] month_i,
  input  logic [rtc_pkg::DATA_W-1:0] year_i,
  input  logic [rtc_pkg::DATA_W-1:0] weekday_i,
  input  logic [rtc_pkg::DATA_W-1:0] weeknum_i,
  output logic                       wr_o,
  output logic [rtc_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [rtc_pkg::DATA_W-1:0] wr_data_o
);

  logic [rtc_pkg::DATA_W-1:0] values [rtc_pkg::FIELD_COUNT];
  logic [rtc_pkg::DATA_W-1:0] cur_val;
  logic [rtc_pkg::DATA_W-1:0] new_val;
  logic [rtc_pkg::ADDR_W-1:0] field_addr;
  logic                       edit_req;
  logic                       wr_q;

  // read-back values in chip order
  assign values[0] = seconds_i;
  assign values[1] = minutes_i;
  assign values[2] = hours_i;
  assign values[3] = date_i;
  assign values[4] = month_i;
  assign values[5] = year_i;
  assign values[6] = weekday_i;
  assign values[7] = weeknum_i;

  assign cur_val = values[field_i];
  assign new_val = up_i ? cur_val + 1'b1 : cur_val - 1'b1; // wraps mod 256

  assign field_addr = rtc_pkg::FIELD_BASE_ADDR
                    + {{(rtc_pkg::ADDR_W-rtc_pkg::FIELD_W){1'b0}}, field_i};

  // both buttons at once cancel out
  assign edit_req = (up_i ^ down_i) & ~busy_i;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      wr_q <= 1'b0;
    else
      wr_q <= cmd_wr_i | edit_req;
  end

  always_ff @(posedge clk)
  begin
    if (cmd_wr_i)
    begin
      wr_addr_o <= rtc_pkg::CTRL_ADDR; // init commands win
      wr_data_o <= cmd_data_i;
    end
    else if (edit_req)
    begin
      wr_addr_o <= field_addr;
      wr_data_o <= new_val;
    end
  end

  assign wr_o = wr_q;

endmodule

`default_nettype wire

//--- logic/init_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module init_sequencer (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       start_i,
  output logic                       busy_o,
  output logic                       rtc_reset_o,
  output logic                       cmd_wr_o,
  output logic [rtc_pkg::DATA_W-1:0] cmd_data_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HOLD, // chip held in reset, counting down
    ST_TAIL  // clear command issued, busy drops next
  } state_e;

  state_e                           state_q;
  logic [rtc_pkg::INIT_CNT_W-1:0]   cnt_q;
  logic                             cmd_wr_q;
  logic [rtc_pkg::DATA_W-1:0]       cmd_data_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q  <= ST_IDLE;
      cnt_q    <= '0;
      cmd_wr_q <= 1'b0;
    end
    else
    begin
      cmd_wr_q <= 1'b0;
      case (state_q)
        ST_IDLE:
        begin
          if (start_i)
          begin
            state_q  <= ST_HOLD;
            cnt_q    <= rtc_pkg::INIT_CYCLES;
            cmd_wr_q <= 1'b1; // reset command
          end
        end
        ST_HOLD:
        begin
          if (cnt_q == '0)
          begin
            state_q  <= ST_TAIL;
            cmd_wr_q <= 1'b1; // clear command
          end
          else
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == ST_IDLE)
      cmd_data_q <= rtc_pkg::CTRL_RESET;
    else if (state_q == ST_HOLD && cnt_q == '0)
      cmd_data_q <= rtc_pkg::CTRL_CLEAR;
  end

  assign busy_o      = (state_q != ST_IDLE);
  assign rtc_reset_o = (state_q == ST_HOLD);
  assign cmd_wr_o    = cmd_wr_q;
  assign cmd_data_o  = cmd_data_q;

endmodule

`default_nettype wire

//--- logic/rtc_writer_top.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_writer_top (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       start_i,
  input  logic                       btn_up_i,
  input  logic                       btn_down_i,
  input  logic                       btn_left_i,
  input  logic                       btn_right_i,
  input  logic [rtc_pkg::DATA_W-1:0] seconds_i,
  input  logic [rtc_pkg::DATA_W-1:0] minutes_i,
  input  logic [rtc_pkg::DATA_W-1:0] hours_i,
  input  logic [rtc_pkg::DATA_W-1:0] date_i,
  input  logic [rtc_pkg::DATA_W-1:0] month_i,
  input  logic [rtc_pkg::DATA_W-1:0] year_i,
  input  logic [rtc_pkg::DATA_W-1:0] weekday_i,
  input  logic [rtc_pkg::DATA_W-1:0] weeknum_i,
  output logic                       rtc_reset_o,
  output logic                       busy_o,
  output logic                       wr_o,
  output logic [rtc_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [rtc_pkg::DATA_W-1:0] wr_data_o
);

  logic                       up_press;
  logic                       down_press;
  logic                       left_press;
  logic                       right_press;
  rtc_pkg::field_e            field_sel;
  logic                       cmd_wr;
  logic [rtc_pkg::DATA_W-1:0] cmd_data;

  button_pulser u_btn_up (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .button_i (btn_up_i),
    .press_o  (up_press)
  );

  button_pulser u_btn_down (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .button_i (btn_down_i),
    .press_o  (down_press)
  );

  button_pulser u_btn_left (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .button_i (btn_left_i),
    .press_o  (left_press)
  );

  button_pulser u_btn_right (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .button_i (btn_right_i),
    .press_o  (right_press)
  );

  field_cursor u_cursor (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .left_i  (left_press),
    .right_i (right_press),
    .field_o (field_sel)
  );

  init_sequencer u_init (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (start_i),
    .busy_o      (busy_o),
    .rtc_reset_o (rtc_reset_o),
    .cmd_wr_o    (cmd_wr),
    .cmd_data_o  (cmd_data)
  );

  field_editor u_editor (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .up_i       (up_press),
    .down_i     (down_press),
    .busy_i     (busy_o),
    .cmd_wr_i   (cmd_wr),
    .cmd_data_i (cmd_data),
    .field_i    (field_sel),
    .seconds_i  (seconds_i),
    .minutes_i  (minutes_i),
    .hours_i    (hours_i),
    .date_i     (date_i),
    .month_i    (month_i),
    .year_i     (year_i),
    .weekday_i  (weekday_i),
    .weeknum_i  (weeknum_i),
    .wr_o       (wr_o),
    .wr_addr_o  (wr_addr_o),
    .wr_data_o  (wr_data_o)
  );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module rtc_writer_tb \
  -f vlog.f -o rtc_writer_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/rtc_writer_sim > sim.log 2>&1 || echo "simulation stopped with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

//--- testbench/rtc_writer_sva.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_writer_sva (
  input logic                       clk,
  input logic                       rst_n_i,
  input logic                       wr_i,
  input logic                       busy_i,
  input logic                       rtc_reset_i,
  input logic [rtc_pkg::ADDR_W-1:0] wr_addr_i
);

  // never two writes in a row
  a_single_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_i |=> !wr_i)
    else $error("wr_o high on two consecutive cycles");

  a_reset_in_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    !busy_i |-> !rtc_reset_i)
    else $error("rtc_reset_o high while busy_o is low");

  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wr_i && !rtc_reset_i) |-> (wr_addr_i == rtc_pkg::CTRL_ADDR
      || (wr_addr_i >= rtc_pkg::FIELD_BASE_ADDR
          && wr_addr_i <= rtc_pkg::FIELD_BASE_ADDR + rtc_pkg::FIELD_COUNT - 1)))
    else $error("write to an address outside the register map");

endmodule

bind rtc_writer_top rtc_writer_sva u_sva (
  .clk         (clk),
  .rst_n_i     (rst_n_i),
  .wr_i        (wr_o),
  .busy_i      (busy_o),
  .rtc_reset_i (rtc_reset_o),
  .wr_addr_i   (wr_addr_o)
);

`default_nettype wire

//--- testbench/rtc_writer_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rtc_writer_tb;

  localparam int WAIT_LIMIT = 200; // init alone takes about 80 cycles
  localparam int SETTLE     = 6;
  localparam int BTN_UP     = 0;
  localparam int BTN_DOWN   = 1;
  localparam int BTN_LEFT   = 2;
  localparam int BTN_RIGHT  = 3;

  logic       clk;
  logic       rst_n;
  logic       start;
  logic [3:0] btn; // up, down, left, right
  logic [7:0] field_val [8];
  logic       rtc_reset;
  logic       busy;
  logic       wr;
  logic [7:0] wr_addr;
  logic [7:0] wr_data;
  int         errors;
  int         timeouts;
  int         seed;
  int         cursor; // field the DUT should have selected

  rtc_writer_top dut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .start_i     (start),
    .btn_up_i    (btn[BTN_UP]),
    .btn_down_i  (btn[BTN_DOWN]),
    .btn_left_i  (btn[BTN_LEFT]),
    .btn_right_i (btn[BTN_RIGHT]),
    .seconds_i   (field_val[0]),
    .minutes_i   (field_val[1]),
    .hours_i     (field_val[2]),
    .date_i      (field_val[3]),
    .month_i     (field_val[4]),
    .year_i      (field_val[5]),
    .weekday_i   (field_val[6]),
    .weeknum_i   (field_val[7]),
    .rtc_reset_o (rtc_reset),
    .busy_o      (busy),
    .wr_o        (wr),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data)
  );

  always #10 clk = ~clk;

  task automatic check(input string name, input logic [31:0] act, input logic [31:0] expected);
    if (act !== expected)
    begin
      $display("Fail %s: got %h, expected %h", name, act, expected);
      errors++;
    end
  endtask

  task automatic press(input int which, input int hold);
    @(posedge clk);
    btn[which] <= 1'b1;
    repeat (hold) @(posedge clk);
    btn[which] <= 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_write(output bit seen, output int cycles);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < WAIT_LIMIT)
    begin
      @(negedge clk);
      cycles++;
      seen = wr;
    end
    if (!seen)
    begin
      $display("timeout: no write to the chip within %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic count_writes(input int cycles, output int count);
    count = 0;
    repeat (cycles)
    begin
      @(negedge clk);
      if (wr)
        count++;
    end
  endtask

  task automatic edit_and_check(input int which, input logic [7:0] exp_addr,
                                input logic [7:0] exp_data);
    bit seen;
    int cycles;
    press(which, 2);
    wait_write(seen, cycles);
    if (seen)
    begin
      check("wr_addr_o", wr_addr, exp_addr);
      check("wr_data_o", wr_data, exp_data);
    end
    repeat (SETTLE) @(posedge clk);
  endtask

  task automatic move_cursor(input int which, input int times);
    int count;
    repeat (times)
    begin
      press(which, 2);
      count_writes(SETTLE, count); // a move never writes
      check("writes on cursor move", count, 0);
    end
  endtask

  task automatic load_fields();
    int r;
    @(posedge clk);
    for (int k = 0; k < 8; k++)
    begin
      r = $random(seed);
      field_val[k] <= r[7:0];
    end
  endtask

  task automatic after_reset();
    @(negedge clk);
    check("wr_o", wr, 0);
    check("busy_o", busy, 0);
    check("rtc_reset_o", rtc_reset, 0);
  endtask

  task automatic init_sequence();
    bit seen;
    int gap;
    int extra;
    pulse_start();
    wait_write(seen, gap);
    if (seen)
    begin
      check("wr_addr_o", wr_addr, rtc_pkg::CTRL_ADDR);
      check("wr_data_o", wr_data, rtc_pkg::CTRL_RESET);
      check("rtc_reset_o", rtc_reset, 1);
    end
    wait_write(seen, gap);
    if (seen)
    begin
      check("cycles between init writes", gap, rtc_pkg::INIT_CYCLES + 1);
      check("wr_addr_o", wr_addr, rtc_pkg::CTRL_ADDR);
      check("wr_data_o", wr_data, rtc_pkg::CTRL_CLEAR);
    end
    check("busy_o", busy, 0); // falls together with the clear write
    count_writes(SETTLE, extra);
    check("writes after init", extra, 0);
  endtask

  task automatic edit_seconds();
    edit_and_check(BTN_UP, rtc_pkg::FIELD_BASE_ADDR, field_val[0] + 8'd1);
    @(posedge clk);
    field_val[0] <= 8'hff;
    edit_and_check(BTN_UP, 8'h21, 8'h00); // wraps
    edit_and_check(BTN_DOWN, 8'h21, 8'hfe);
  endtask

  task automatic field_select();
    int steps [3];
    steps = '{1, 2, 5};
    for (int i = 0; i < 3; i++)
    begin
      move_cursor(BTN_RIGHT, steps[i]);
      cursor = (cursor + steps[i]) % 8;
      edit_and_check(BTN_UP, rtc_pkg::FIELD_BASE_ADDR + 8'(cursor), field_val[cursor] + 8'd1);
    end
    move_cursor(BTN_LEFT, 1);
    cursor = (cursor + 7) % 8;
    edit_and_check(BTN_UP, 8'h28, field_val[cursor] + 8'd1); // week number
  endtask

  task automatic held_button();
    int held;
    int after;
    @(posedge clk);
    btn[BTN_UP] <= 1'b1;
    count_writes(40, held);
    @(posedge clk);
    btn[BTN_UP] <= 1'b0;
    count_writes(SETTLE, after);
    check("writes per held press", held + after, 1);
  endtask

  task automatic edit_while_busy();
    int n;
    int field_writes;
    int later;
    n            = 0;
    field_writes = 0;
    pulse_start();
    press(BTN_UP, 2);
    do
    begin
      @(negedge clk);
      n++;
      if (wr && wr_addr != rtc_pkg::CTRL_ADDR)
        field_writes++;
    end
    while (busy && n < WAIT_LIMIT);
    if (busy)
    begin
      $display("timeout: busy_o still high after %0d cycles", WAIT_LIMIT);
      timeouts++;
    end
    check("field writes during init", field_writes, 0);
    count_writes(SETTLE, later);
    check("writes after init", later, 0);
  endtask

  initial
  begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    start    = 1'b0;
    btn      = 4'b0000;
    errors   = 0;
    timeouts = 0;
    seed     = 32'hcad0;
    cursor   = 0;
    for (int k = 0; k < 8; k++)
      field_val[k] = 8'h00;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    after_reset();
    load_fields();
    init_sequence();
    edit_seconds();
    field_select();
    held_button();
    edit_while_busy();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/rtc_pkg.sv
buttons/button_pulser.sv
logic/field_cursor.sv
logic/init_sequencer.sv
logic/field_editor.sv
logic/rtc_writer_top.sv
testbench/rtc_writer_sva.sv
testbench/rtc_writer_tb.sv
